/* Bender.yml */
package:
  name: fetch

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_if.sv
  - hdl/addr_calculate.sv
  - hdl/cache_access.sv
  - hdl/result_drive.sv
  - hdl/fetch.sv
  - target: test
    files:
      - tests/fetch_checker.sv
      - tests/tb_fetch.sv

/* flist.f */
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/addr_calculate.sv
hdl/cache_access.sv
hdl/result_drive.sv
hdl/fetch.sv
tests/fetch_checker.sv
tests/tb_fetch.sv

/* hdl/addr_calculate.sv */
`timescale 1ns/10ps

module addr_calculate
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              rst_i,

  input  logic              flush_i,
  input  logic [ADDR_W-1:0] dnpc_i,

  output logic              valid_post_o,
  input  logic              ready_post_i,

  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;
  logic              valid_q;

  // redirect wins over the sequential step
  always_ff @(posedge clock) begin
    if (rst_i) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;   // always something to fetch
      if (flush_i) begin
        pc_q <= dnpc_i;
      end else if (valid_q && ready_post_i) begin
        pc_q <= pc_q + ADDR_W'(4);
      end
    end
  end

  assign valid_post_o = valid_q;
  assign pc_o         = pc_q;

endmodule

/* hdl/cache_access.sv */
`timescale 1ns/10ps

module cache_access
  import fetch_pkg::*;
#(
  parameter int SETS = 16,
  parameter int WAYS = 2
)(
  input  logic              clock,
  input  logic              rst_i,
  input  logic              flush_i,

  input  logic              valid_pre_i,
  output logic              ready_pre_o,
  input  logic [ADDR_W-1:0] pc_i,

  lookup_if.cache_side      lookup,
  line_wr_if.array          wr
);

  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1;
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

  logic [WAYS-1:0]   valid_q  [SETS];
  logic [WAY_W-1:0]  victim_q [SETS];
  logic [TAG_W-1:0]  tag_q    [SETS][WAYS];
  logic [LINE_W-1:0] data_q   [SETS][WAYS];

  logic               held_valid;
  logic [ADDR_W-1:0]  held_pc;
  logic               held_hit;
  logic [LINE_W-1:0]  held_line;
  logic [WAY_W-1:0]   held_way;

  logic [INDEX_W-1:0] idx_c;
  logic [TAG_W-1:0]   tag_c;
  logic               hit_c;
  logic [WAY_W-1:0]   way_c;
  logic [LINE_W-1:0]  line_c;
  logic               accept;

  function automatic logic [WAY_W-1:0] next_way(input logic [WAY_W-1:0] w);
    return (w == WAY_W'(WAYS - 1)) ? '0 : w + 1'b1;
  endfunction

  assign idx_c  = pc_i[OFFSET_W +: INDEX_W];
  assign tag_c  = pc_i[ADDR_W-1 -: TAG_W];
  assign accept = valid_pre_i && ready_pre_o && !flush_i;

  // slot free, or emptied this cycle
  assign ready_pre_o = !held_valid || lookup.ready;

  always_comb begin
    hit_c  = 1'b0;
    way_c  = victim_q[idx_c];
    line_c = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid_q[idx_c][w] && tag_q[idx_c][w] == tag_c) begin
        hit_c  = 1'b1;
        way_c  = WAY_W'(w);
        line_c = data_q[idx_c][w];
      end
    end
    // refill landing this very cycle
    if (wr.wen && wr.index == idx_c) begin
      if (wr.tag == tag_c) begin
        hit_c  = 1'b1;
        way_c  = wr.way;
        line_c = wr.line;
      end else if (!hit_c) begin
        way_c = next_way(victim_q[idx_c]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      held_valid <= 1'b0;
      for (int s = 0; s < SETS; s++) begin
        valid_q[s]  <= '0;
        victim_q[s] <= '0;
      end
    end else begin
      if (flush_i) begin
        held_valid <= 1'b0;
      end else if (accept) begin
        held_valid <= 1'b1;
      end else if (lookup.ready) begin
        held_valid <= 1'b0;
      end
      if (wr.wen) begin
        valid_q[wr.index][wr.way] <= 1'b1;
        victim_q[wr.index]        <= next_way(victim_q[wr.index]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr.wen) begin
      tag_q[wr.index][wr.way]  <= wr.tag;
      data_q[wr.index][wr.way] <= wr.line;
    end
    if (accept) begin
      held_pc   <= pc_i;
      held_hit  <= hit_c;
      held_line <= line_c;
      held_way  <= way_c;
    end else if (wr.wen && wr.index == held_pc[OFFSET_W +: INDEX_W]) begin
      if (wr.tag == held_pc[ADDR_W-1 -: TAG_W]) begin
        held_hit  <= 1'b1;   // refilled while waiting
        held_line <= wr.line;
        held_way  <= wr.way;
      end else if (!held_hit) begin
        held_way <= next_way(victim_q[wr.index]);
      end
    end
  end

  assign lookup.valid    = held_valid;
  assign lookup.pc       = held_pc;
  assign lookup.hit      = held_hit;
  assign lookup.hit_line = held_line;
  assign lookup.hit_way  = held_way;

endmodule

/* hdl/fetch.sv */
`timescale 1ns/10ps

module fetch
  import fetch_pkg::*;
#(
  parameter int SETS = 16,
  parameter int WAYS = 2
)(
  input  logic              clock,
  input  logic              rst_i,

  // redirect from decode
  input  logic              flush_i,
  input  logic [ADDR_W-1:0] dnpc_i,

  // fetch -> decode
  output logic              valid_post_o,
  input  logic              ready_post_i,
  output logic [ADDR_W-1:0] pc_o,
  output logic [INST_W-1:0] inst_o,
  output logic              inst_err_o,

  // AR channel
  input  logic              arready_i,
  output logic              arvalid_o,
  output logic [ADDR_W-1:0] araddr_o,

  // R channel
  output logic              rready_o,
  input  logic              rvalid_i,
  input  logic [1:0]        rresp_i,
  input  logic [INST_W-1:0] rdata_i,
  input  logic              rlast_i
);

  logic              valid_addr_access;
  logic              ready_addr_access;
  logic [ADDR_W-1:0] fetch_pc;

  lookup_if  #(.WAYS(WAYS))               lookup_bus ();
  line_wr_if #(.SETS(SETS), .WAYS(WAYS))  wr_bus ();

  addr_calculate addr_calculate0 (
    .clock        (clock),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .dnpc_i       (dnpc_i),
    .valid_post_o (valid_addr_access),
    .ready_post_i (ready_addr_access),
    .pc_o         (fetch_pc)
  );

  cache_access #(.SETS(SETS), .WAYS(WAYS)) cache_access0 (
    .clock       (clock),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .valid_pre_i (valid_addr_access),
    .ready_pre_o (ready_addr_access),
    .pc_i        (fetch_pc),
    .lookup      (lookup_bus.cache_side),
    .wr          (wr_bus.array)
  );

  result_drive #(.SETS(SETS), .WAYS(WAYS)) result_drive0 (
    .clock        (clock),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .lookup       (lookup_bus.drive_side),
    .wr           (wr_bus.writer),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .inst_err_o   (inst_err_o),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .araddr_o     (araddr_o),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i),
    .rresp_i      (rresp_i),
    .rdata_i      (rdata_i),
    .rlast_i      (rlast_i)
  );

endmodule

/* hdl/fetch_if.sv */
`timescale 1ns/10ps

// lookup result, cache_access -> result_drive
interface lookup_if
  import fetch_pkg::*;
#(
  parameter int WAYS = 2
);

  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] pc;
  logic              hit;
  logic [LINE_W-1:0] hit_line;
  logic [WAY_W-1:0]  hit_way;   // victim on a miss

  modport cache_side (output valid, pc, hit, hit_line, hit_way, input ready);
  modport drive_side (input valid, pc, hit, hit_line, hit_way, output ready);

endinterface

// refill write, result_drive -> cache arrays
interface line_wr_if
  import fetch_pkg::*;
#(
  parameter int SETS = 16,
  parameter int WAYS = 2
);

  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1;
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

  logic               wen;
  logic [INDEX_W-1:0] index;
  logic [WAY_W-1:0]   way;
  logic [TAG_W-1:0]   tag;
  logic [LINE_W-1:0]  line;

  modport writer (output wen, index, way, tag, line);
  modport array  (input wen, index, way, tag, line);

endinterface

/* hdl/fetch_pkg.sv */
package fetch_pkg;

  // core widths
  localparam int ADDR_W = 32;
  localparam int INST_W = 32;   // one instruction, one AXI beat

  // line geometry
  localparam int BEATS    = 4;
  localparam int LINE_W   = BEATS * INST_W;
  localparam int OFFSET_W = $clog2(LINE_W / 8);

  // boot address
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // result stage FSM
  typedef enum logic [2:0] {
    IDLE, // nothing held
    HOLD, // hit instruction waiting on the consumer
    AR,   // burst address out
    R,    // collecting beats
    DONE  // refill written, miss instruction out
  } rd_state_e;

endpackage

/* hdl/result_drive.sv */
`timescale 1ns/10ps

module result_drive
  import fetch_pkg::*;
#(
  parameter int SETS = 16,
  parameter int WAYS = 2
)(
  input  logic              clock,
  input  logic              rst_i,
  input  logic              flush_i,

  lookup_if.drive_side      lookup,
  line_wr_if.writer         wr,

  output logic              valid_post_o,
  input  logic              ready_post_i,
  output logic [ADDR_W-1:0] pc_o,
  output logic [INST_W-1:0] inst_o,
  output logic              inst_err_o,

  // AXI read address
  input  logic              arready_i,
  output logic              arvalid_o,
  output logic [ADDR_W-1:0] araddr_o,

  // AXI read data
  output logic              rready_o,
  input  logic              rvalid_i,
  input  logic [1:0]        rresp_i,
  input  logic [INST_W-1:0] rdata_i,
  input  logic              rlast_i
);

  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1;
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

  rd_state_e         state;
  logic              out_valid;
  logic              wen_q;
  logic              drop_q;    // flushed while the burst runs

  logic [ADDR_W-1:0] out_pc;
  logic [INST_W-1:0] out_inst;
  logic              out_err;
  logic [WAY_W-1:0]  way_q;
  logic [LINE_W-1:0] line_buf;
  logic              err_q;

  logic              accept;
  logic              beat;
  logic              last;
  logic              resp_err;
  logic [LINE_W-1:0] line_next;

  function automatic logic [INST_W-1:0] word_sel(input logic [LINE_W-1:0] line,
                                                 input logic [OFFSET_W-3:0] sel);
    return line[sel*INST_W +: INST_W];
  endfunction

  // no new lookup while a refill write is landing
  assign lookup.ready = !wen_q &&
                        (state == IDLE ||
                         ((state == HOLD || state == DONE) && (!out_valid || ready_post_i)));

  assign accept    = lookup.valid && lookup.ready && !flush_i;
  assign beat      = (state == R) && rvalid_i;
  assign last      = beat && rlast_i;
  assign resp_err  = rresp_i != 2'b00;
  assign line_next = {rdata_i, line_buf[LINE_W-1:INST_W]};   // first beat ends up lowest

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state     <= IDLE;
      out_valid <= 1'b0;
      wen_q     <= 1'b0;
      drop_q    <= 1'b0;
    end else begin
      wen_q <= 1'b0;
      case (state)
        IDLE, HOLD, DONE: begin
          if (flush_i) begin
            state     <= IDLE;
            out_valid <= 1'b0;
          end else if (accept) begin
            state     <= lookup.hit ? HOLD : AR;
            out_valid <= lookup.hit;
            drop_q    <= 1'b0;
          end else if (!out_valid || ready_post_i) begin
            state     <= IDLE;
            out_valid <= 1'b0;
          end
        end
        AR: begin
          if (flush_i) drop_q <= 1'b1;
          if (arready_i) state <= R;
        end
        R: begin
          if (flush_i) drop_q <= 1'b1;
          if (last) begin
            state     <= DONE;
            wen_q     <= !(err_q || resp_err);   // bad line never cached
            out_valid <= !(drop_q || flush_i);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out_pc   <= lookup.pc;
      way_q    <= lookup.hit_way;
      out_inst <= word_sel(lookup.hit_line, lookup.pc[OFFSET_W-1:2]);
      out_err  <= 1'b0;
      err_q    <= 1'b0;
    end
    if (beat) begin
      line_buf <= line_next;
      err_q    <= err_q || resp_err;
    end
    if (last) begin
      out_err  <= err_q || resp_err;
      out_inst <= (err_q || resp_err) ? '0 : word_sel(line_next, out_pc[OFFSET_W-1:2]);
    end
  end

  assign arvalid_o = (state == AR);
  assign araddr_o  = {out_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign rready_o  = (state == R);

  assign wr.wen   = wen_q;
  assign wr.index = out_pc[OFFSET_W +: INDEX_W];
  assign wr.way   = way_q;
  assign wr.tag   = out_pc[ADDR_W-1 -: TAG_W];
  assign wr.line  = line_buf;

  assign valid_post_o = out_valid;
  assign pc_o         = out_pc;
  assign inst_o       = out_inst;
  assign inst_err_o   = out_err;

endmodule

/* tests/fetch_checker.sv */
`timescale 1ns/10ps

module fetch_checker
  import fetch_pkg::*;
(
  input logic              clock,
  input logic              rst_i,
  input logic              flush_i,
  input logic              valid_post_o,
  input logic              ready_post_i,
  input logic [ADDR_W-1:0] pc_o,
  input logic              arvalid_o,
  input logic              arready_i,
  input logic [ADDR_W-1:0] araddr_o
);

  int fail_count = 0;   // read by the testbench

  // AR request held until accepted
  ar_stable: assert property (@(posedge clock) disable iff (rst_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else begin
      fail_count++;
      $error("AR request changed before arready");
    end

  // a redirect may withdraw the output
  out_stable: assert property (@(posedge clock) disable iff (rst_i)
    valid_post_o && !ready_post_i && !flush_i |=> valid_post_o && $stable(pc_o))
    else begin
      fail_count++;
      $error("fetch output changed before ready_post_i");
    end

  ar_aligned: assert property (@(posedge clock) disable iff (rst_i)
    arvalid_o |-> araddr_o[OFFSET_W-1:0] == '0)
    else begin
      fail_count++;
      $error("araddr %h not line aligned", araddr_o);
    end

endmodule

bind fetch fetch_checker chk (.*);

/* tests/tb_fetch.sv */
`timescale 1ns/10ps

module tb_fetch
  import fetch_pkg::*;
();

  localparam int TIMEOUT = 200;   // cycles per wait
  localparam logic [ADDR_W-1:0] ERR_PC = 32'h9000_0000;

  logic              clock;
  logic              rst_i        = 1'b1;
  logic              flush_i      = 1'b0;
  logic [ADDR_W-1:0] dnpc_i       = '0;
  logic              valid_post_o;
  logic              ready_post_i = 1'b0;
  logic [ADDR_W-1:0] pc_o;
  logic [INST_W-1:0] inst_o;
  logic              inst_err_o;
  logic              arready_i    = 1'b0;
  logic              arvalid_o;
  logic [ADDR_W-1:0] araddr_o;
  logic              rready_o;
  logic              rvalid_i     = 1'b0;
  logic [1:0]        rresp_i      = '0;
  logic [INST_W-1:0] rdata_i      = '0;
  logic              rlast_i      = 1'b0;

  integer            seed      = 81306;
  int                errors    = 0;
  int                ar_count  = 0;
  bit                hung      = 1'b0;
  int                mem_state = 0;
  int                delay     = 0;
  int                beat_no   = 0;
  logic [ADDR_W-1:0] burst_addr;

  fetch #(.SETS(16), .WAYS(2)) uut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [INST_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    return a ^ 32'h5A5A_5A5A;
  endfunction

  function automatic logic in_err_region(input logic [ADDR_W-1:0] a);
    return a[ADDR_W-1:8] == ERR_PC[ADDR_W-1:8];
  endfunction

  task automatic present_beat(input logic [ADDR_W-1:0] a, input int n);
    rvalid_i <= 1'b1;
    rdata_i  <= mem_word(a);
    rresp_i  <= in_err_region(a) ? 2'b10 : 2'b00;   // SLVERR
    rlast_i  <= (n == BEATS - 1);
  endtask

  // AXI slave serving one burst at a time
  always @(posedge clock) begin
    if (rst_i) begin
      mem_state <= 0;
      arready_i <= 1'b0;
      rvalid_i  <= 1'b0;
      rlast_i   <= 1'b0;
      ar_count  <= 0;
    end else begin
      case (mem_state)
        0: if (arvalid_o) begin
          delay     <= $random(seed) & 3;
          mem_state <= 1;
        end
        1: if (delay == 0) begin
          arready_i <= 1'b1;
          mem_state <= 2;
        end else begin
          delay <= delay - 1;
        end
        2: begin   // AR handshake on this edge
          arready_i  <= 1'b0;
          ar_count   <= ar_count + 1;
          burst_addr <= araddr_o;
          beat_no    <= 0;
          present_beat(araddr_o, 0);
          mem_state  <= 3;
        end
        default: if (rvalid_i && rready_o) begin
          if (rlast_i) begin
            rvalid_i  <= 1'b0;
            rlast_i   <= 1'b0;
            mem_state <= 0;
          end else begin
            beat_no <= beat_no + 1;
            present_beat(burst_addr + 4 * (beat_no + 1), beat_no + 1);
          end
        end
      endcase
    end
  end

  task automatic note_error(input string msg);
    errors++;
    $display("[ERROR] %0d ns: %s", $time, msg);
  endtask

  task automatic give_up(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    hung = 1'b1;
  endtask

  // wait until the output stage holds something while ready stays low
  task automatic settle();
    int t;
    t = 0;
    @(posedge clock);   // an output taken on this edge still reads as valid
    while (!valid_post_o && !hung) begin
      @(posedge clock);
      t++;
      if (t > TIMEOUT) give_up("held fetch output");
    end
  endtask

  task automatic redirect(input logic [ADDR_W-1:0] target);
    flush_i <= 1'b1;
    dnpc_i  <= target;
    @(posedge clock);
    flush_i <= 1'b0;
  endtask

  // take n instructions from start
  task automatic collect(input logic [ADDR_W-1:0] start, input int n, input bit random_ready,
                         output int ar_seen);   // AR count at the last transfer
    logic [ADDR_W-1:0] exp_pc;
    logic [INST_W-1:0] exp_inst;
    logic              exp_err;
    int                got;
    int                idle;
    exp_pc  = start;
    got     = 0;
    idle    = 0;
    ar_seen = ar_count;
    while (got < n && !hung) begin
      @(posedge clock);
      if (valid_post_o && ready_post_i) begin
        exp_err  = in_err_region(exp_pc);
        exp_inst = exp_err ? '0 : mem_word(exp_pc);
        assert (pc_o == exp_pc)
          else note_error($sformatf("pc_o %h, expected %h", pc_o, exp_pc));
        assert (inst_o == exp_inst && inst_err_o == exp_err)
          else note_error($sformatf("pc %h: inst_o %h err %b, expected %h err %b",
                                    exp_pc, inst_o, inst_err_o, exp_inst, exp_err));
        ar_seen = ar_count;
        exp_pc  = exp_pc + 4;
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) give_up("fetch output");
      end
      if (got == n) ready_post_i <= 1'b0;
      else ready_post_i <= random_ready ? 1'($random(seed)) : 1'b1;
    end
  endtask

  task automatic reset_outputs();
    repeat (2) begin
      @(posedge clock);
      @(negedge clock);
      assert (!valid_post_o && !arvalid_o && !rready_o)
        else note_error("outputs active during reset");
    end
    @(posedge clock);
    rst_i <= 1'b0;
    repeat (2) begin
      @(negedge clock);
      assert (!valid_post_o && !arvalid_o && !rready_o)
        else note_error("outputs active right after reset");
      @(posedge clock);
    end
    settle();
    assert (pc_o == RESET_PC) else note_error($sformatf("first pc %h", pc_o));
  endtask

  task automatic stream_from_reset();
    int seen;
    collect(RESET_PC, 32, 1'b0, seen);
    assert (seen == 8) else note_error($sformatf("%0d AR handshakes, expected 8", seen));
  endtask

  task automatic flush_and_reuse();
    int base;
    int seen;
    settle();   // let the prefetch burst finish
    base = ar_count;
    redirect(RESET_PC);
    collect(RESET_PC, 32, 1'b0, seen);
    assert (seen == base) else note_error($sformatf("%0d refetches", seen - base));
  endtask

  task automatic random_backpressure();
    int seen;
    settle();
    redirect(32'h8000_0200);
    collect(32'h8000_0200, 24, 1'b1, seen);
  endtask

  task automatic round_robin_eviction();
    logic [ADDR_W-1:0] lines [4];
    int                base;
    int                seen;
    lines = '{32'h8000_10C0, 32'h8000_11C0, 32'h8000_12C0, 32'h8000_10C0};   // all set 12
    settle();
    base = ar_count;
    foreach (lines[i]) begin
      settle();
      redirect(lines[i]);
      collect(lines[i], 1, 1'b0, seen);
    end
    assert (seen - base == 4)
      else note_error($sformatf("%0d AR handshakes, expected 4", seen - base));
  endtask

  task automatic error_response();
    int base;
    int seen;
    repeat (2) begin
      settle();
      base = ar_count;
      redirect(ERR_PC);
      collect(ERR_PC, 1, 1'b0, seen);
      assert (seen == base + 1)
        else note_error($sformatf("%0d AR handshakes, expected 1", seen - base));
    end
  endtask

  initial begin
    reset_outputs();
    stream_from_reset();
    flush_and_reuse();
    random_backpressure();
    round_robin_eviction();
    error_response();
    $display("errors: %0d, checker failures: %0d, timeouts: %0d",
             errors, uut.chk.fail_count, hung);
    if (errors == 0 && uut.chk.fail_count == 0 && !hung) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
